// File: core_pkg.sv
// core types and fetch constants; addresses and instructions are 32 bits and fetch targets are word aligned.
`default_nettype none

package core_pkg;

	// Instruction address, byte addressed.
	typedef logic [31:0] pc_t;

	// Raw instruction word as stored in memory.
	typedef logic [31:0] inst_t;

	localparam pc_t RESET_PC = 32'h0000_0000; // first fetch after reset.
	localparam pc_t PC_STEP = 32'd4; // no compressed instructions, so always one word.

endpackage

`default_nettype wire

// File: bus_pkg.sv
// read-data channel response codes; only OKAY and SLVERR are ever produced by the memory.
`default_nettype none

package bus_pkg;

	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY = 2'b00; // good read.
	localparam resp_t RESP_SLVERR = 2'b10; // address beyond the memory depth.

endpackage

`default_nettype wire

// File: pc_gen.sv
// program counter with one pending redirect; pc must stay stable while busy so araddr holds during a request.
`timescale 1ns/1ps
`default_nettype none

module pc_gen (
	input  logic          clk,
	input  logic          rst,
	input  logic          busy,
	input  logic          advance,
	input  logic          redirect_valid,
	input  core_pkg::pc_t redirect_target,
	output core_pkg::pc_t pc
);
	import core_pkg::*;

	pc_t  pend_target;
	logic pend_valid;

	// The pc only moves outside a transaction, except for the step on a kept fetch.
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
			pend_valid <= 1'b0;
		end else if (!busy) begin
			if (redirect_valid) begin
				pc <= redirect_target; // a fresh target beats an older pending one.
			end else if (pend_valid) begin
				pc <= pend_target;
			end
			pend_valid <= 1'b0;
		end else begin
			if (redirect_valid) begin
				pend_valid <= 1'b1; // applied on the first idle cycle.
			end
			if (advance) begin
				pc <= pc + PC_STEP;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (busy && redirect_valid) begin
			pend_target <= redirect_target; // the latest target wins.
		end
	end

endmodule

`default_nettype wire

// File: fetch_ctrl.sv
// one read in flight at a time; a redirect during a read drops that read instead of aborting it on the bus.
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic redirect_valid,
	input  logic slot_valid,
	input  logic decode_allowin,
	input  logic arready,
	input  logic rvalid,
	output logic arvalid,
	output logic rready,
	output logic busy,
	output logic advance,
	output logic capture
);

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		WAIT_R
	} fetch_state_t;

	fetch_state_t state;
	fetch_state_t state_next;
	logic         drop;
	logic         ar_shake;
	logic         r_shake;
	logic         keep;

	assign arvalid = (state == REQ);
	assign rready = (state == WAIT_R);
	assign busy = (state != IDLE);
	assign ar_shake = arvalid && arready;
	assign r_shake = rvalid && rready;

	// A redirect on the handshake cycle itself also kills the data.
	assign keep = r_shake && !drop && !redirect_valid;
	assign advance = keep;
	assign capture = keep;

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				// start only when the slot will have room for the result.
				if (!slot_valid || decode_allowin) begin
					state_next = REQ;
				end
			end
			REQ: begin
				if (ar_shake) begin
					state_next = WAIT_R;
				end
			end
			WAIT_R: begin
				if (r_shake) begin
					state_next = IDLE;
				end
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// drop lives for one transaction and is cleared when the data returns.
	always_ff @(posedge clk) begin
		if (rst) begin
			drop <= 1'b0;
		end else if (r_shake) begin
			drop <= 1'b0;
		end else if (busy && redirect_valid) begin
			drop <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: inst_latch.sv
// one-entry output slot; capture is only ever raised when the slot is empty or being taken that cycle.
`timescale 1ns/1ps
`default_nettype none

module inst_latch (
	input  logic            clk,
	input  logic            rst,
	input  logic            capture,
	input  logic            decode_allowin,
	input  core_pkg::pc_t   pc,
	input  core_pkg::inst_t rdata,
	input  bus_pkg::resp_t  rresp,
	output logic            fetch_valid,
	output core_pkg::pc_t   fetch_pc,
	output core_pkg::inst_t fetch_inst,
	output logic            fetch_fault
);
	import bus_pkg::*;

	always_ff @(posedge clk) begin
		if (rst) begin
			fetch_valid <= 1'b0;
		end else if (capture) begin
			fetch_valid <= 1'b1;
		end else if (decode_allowin) begin
			fetch_valid <= 1'b0; // taken with nothing new behind it.
		end
	end

	// pc still points at the fetched word here, since the step lands on this same edge.
	always_ff @(posedge clk) begin
		if (capture) begin
			fetch_pc <= pc;
			fetch_inst <= rdata;
			fetch_fault <= (rresp != RESP_OKAY);
		end
	end

endmodule

`default_nettype wire

// File: isram.sv
// instruction memory model loaded from prog.hex; needs R_LAT >= 1, AR_LAT and R_LAT below 256, word-aligned reads.
`timescale 1ns/1ps
`default_nettype none

module isram #(
	parameter int MEM_WORDS = 32,
	parameter int AR_LAT = 1,
	parameter int R_LAT = 2
) (
	input  logic            clk,
	input  logic            rst,
	input  core_pkg::pc_t   araddr,
	input  logic            arvalid,
	output logic            arready,
	output logic            rvalid,
	output core_pkg::inst_t rdata,
	output bus_pkg::resp_t  rresp,
	input  logic            rready
);
	import core_pkg::*;
	import bus_pkg::*;

	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
	localparam int CNT_W = 8;

	inst_t            mem [MEM_WORDS];
	logic [CNT_W-1:0] ar_cnt;
	logic [CNT_W-1:0] r_cnt;
	logic [IDX_W-1:0] word_idx;
	logic             in_range;
	logic             ar_shake;

	initial begin
		$readmemh("prog.hex", mem);
	end

	assign word_idx = araddr[IDX_W+1:2];
	assign in_range = (araddr[31:2] < 30'(MEM_WORDS));
	assign arready = arvalid && (ar_cnt == CNT_W'(AR_LAT)); // ready after AR_LAT waiting cycles.
	assign ar_shake = arvalid && arready;

	// Counts how long arvalid has been waiting.
	always_ff @(posedge clk) begin
		if (rst || !arvalid || ar_shake) begin
			ar_cnt <= '0;
		end else begin
			ar_cnt <= ar_cnt + 1'b1;
		end
	end

	// r_cnt runs down to zero as rvalid rises, so it is idle once the data is out.
	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid <= 1'b0;
			r_cnt <= '0;
		end else if (ar_shake) begin
			rvalid <= (R_LAT == 1);
			r_cnt <= CNT_W'(R_LAT - 1);
		end else if (rvalid && rready) begin
			rvalid <= 1'b0;
		end else if (r_cnt != '0) begin
			r_cnt <= r_cnt - 1'b1;
			if (r_cnt == CNT_W'(1)) begin
				rvalid <= 1'b1; // held until rready.
			end
		end
	end

	// The word is read at the address handshake and held through the data phase.
	always_ff @(posedge clk) begin
		if (ar_shake) begin
			if (in_range) begin
				rdata <= mem[word_idx];
				rresp <= RESP_OKAY;
			end else begin
				rdata <= '0;
				rresp <= RESP_SLVERR;
			end
		end
	end

endmodule

`default_nettype wire

// File: fetch_top.sv
// fetch subsystem top; redirect_valid is a one-cycle pulse and redirect targets must be word aligned.
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
	parameter int AR_LAT = 1,
	parameter int R_LAT = 2,
	parameter int MEM_WORDS = 32
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            redirect_valid,
	input  core_pkg::pc_t   redirect_target,
	input  logic            decode_allowin,
	output logic            fetch_valid,
	output core_pkg::pc_t   fetch_pc,
	output core_pkg::inst_t fetch_inst,
	output logic            fetch_fault
);
	import core_pkg::*;
	import bus_pkg::*;

	// Read channel between the controller, the counter and the memory.
	pc_t   araddr;
	logic  arvalid;
	logic  arready;
	logic  rvalid;
	logic  rready;
	inst_t rdata;
	resp_t rresp;

	// Strobes from the controller to the datapath.
	logic busy;
	logic advance;
	logic capture;

	fetch_ctrl i_ctrl (
		.clk           (clk),
		.rst           (rst),
		.redirect_valid(redirect_valid),
		.slot_valid    (fetch_valid), // the slot's valid doubles as its fullness.
		.decode_allowin(decode_allowin),
		.arready       (arready),
		.rvalid        (rvalid),
		.arvalid       (arvalid),
		.rready        (rready),
		.busy          (busy),
		.advance       (advance),
		.capture       (capture)
	);

	pc_gen i_pc (
		.clk            (clk),
		.rst            (rst),
		.busy           (busy),
		.advance        (advance),
		.redirect_valid (redirect_valid),
		.redirect_target(redirect_target),
		.pc             (araddr)
	);

	inst_latch i_latch (
		.clk           (clk),
		.rst           (rst),
		.capture       (capture),
		.decode_allowin(decode_allowin),
		.pc            (araddr),
		.rdata         (rdata),
		.rresp         (rresp),
		.fetch_valid   (fetch_valid),
		.fetch_pc      (fetch_pc),
		.fetch_inst    (fetch_inst),
		.fetch_fault   (fetch_fault)
	);

	isram #(
		.MEM_WORDS(MEM_WORDS),
		.AR_LAT   (AR_LAT),
		.R_LAT    (R_LAT)
	) i_mem (
		.clk    (clk),
		.rst    (rst),
		.araddr (araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rvalid (rvalid),
		.rdata  (rdata),
		.rresp  (rresp),
		.rready (rready)
	);

endmodule

`default_nettype wire

// File: fetch_checker.sv
// fetch output checker; the model is built from prog.hex and assumes word-aligned redirect targets.
`timescale 1ns/1ps
`default_nettype none

module fetch_checker #(
	parameter int MEM_WORDS = 32
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            redirect_valid,
	input  core_pkg::pc_t   redirect_target,
	input  logic            decode_allowin,
	input  logic            fetch_valid,
	input  core_pkg::pc_t   fetch_pc,
	input  core_pkg::inst_t fetch_inst,
	input  logic            fetch_fault,
	output int              error_count,
	output int              item_count
);
	import core_pkg::*;

	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

	inst_t model [MEM_WORDS];
	pc_t   exp_pc;
	logic  next_is_new;
	logic  holding;
	pc_t   held_pc;
	inst_t held_inst;
	logic  held_fault;

	initial begin
		$readmemh("prog.hex", model);
	end

	function automatic logic in_range(input pc_t addr);
		return addr < pc_t'(MEM_WORDS * 4);
	endfunction

	// out-of-range reads come back as zero data.
	function automatic inst_t model_word(input pc_t addr);
		if (in_range(addr)) begin
			return model[addr[IDX_W+1:2]];
		end
		return '0;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			exp_pc = RESET_PC;
			next_is_new = 1'b1;
			holding = 1'b0;
			error_count = 0;
			item_count = 0;
		end else begin
			// an item that was not taken must sit still in the slot.
			if (holding) begin
				compare_value("fetch_valid", 32'd1, 32'(fetch_valid));
				if (fetch_valid) begin
					compare_value("fetch_pc", held_pc, fetch_pc);
					compare_value("fetch_inst", held_inst, fetch_inst);
					compare_value("fetch_fault", 32'(held_fault), 32'(fetch_fault));
				end
			end
			if (fetch_valid && next_is_new) begin
				compare_value("fetch_pc", exp_pc, fetch_pc);
				compare_value("fetch_inst", model_word(exp_pc), fetch_inst);
				compare_value("fetch_fault", 32'(!in_range(exp_pc)), 32'(fetch_fault));
				held_pc = fetch_pc;
				held_inst = fetch_inst;
				held_fault = fetch_fault;
				item_count++;
				exp_pc = exp_pc + PC_STEP;
			end
			holding = fetch_valid && !decode_allowin;
			next_is_new = !fetch_valid || decode_allowin;
			// the slot's item was fetched before this pulse, so the target applies after it.
			if (redirect_valid) begin
				exp_pc = redirect_target;
			end
		end
	end

endmodule

`default_nettype wire

// File: fetch_tb.sv
// fetch subsystem testbench; random redirects and decode stalls from a fixed seed over a fixed run.
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;
	import core_pkg::*;

	localparam int AR_LAT = 1;
	localparam int R_LAT = 2;
	localparam int MEM_WORDS = 32;
	localparam int CLK_PERIOD = 4;
	localparam int RST_CYCLES = 2;
	localparam int RUN_CYCLES = 3000;
	localparam int TGT_WORDS = MEM_WORDS * 3 / 2; // a third of the targets fall past the memory.
	localparam int WATCHDOG_NS = 2 * (RST_CYCLES + RUN_CYCLES) * CLK_PERIOD;

	logic   clk;
	logic   rst;
	logic   redirect_valid;
	pc_t    redirect_target;
	logic   decode_allowin;
	logic   fetch_valid;
	pc_t    fetch_pc;
	inst_t  fetch_inst;
	logic   fetch_fault;
	int     error_count;
	int     item_count;
	int     tb_errors;
	integer seed;

	fetch_top #(
		.AR_LAT   (AR_LAT),
		.R_LAT    (R_LAT),
		.MEM_WORDS(MEM_WORDS)
	) i_dut (
		.clk            (clk),
		.rst            (rst),
		.redirect_valid (redirect_valid),
		.redirect_target(redirect_target),
		.decode_allowin (decode_allowin),
		.fetch_valid    (fetch_valid),
		.fetch_pc       (fetch_pc),
		.fetch_inst     (fetch_inst),
		.fetch_fault    (fetch_fault)
	);

	fetch_checker #(
		.MEM_WORDS(MEM_WORDS)
	) i_checker (
		.clk            (clk),
		.rst            (rst),
		.redirect_valid (redirect_valid),
		.redirect_target(redirect_target),
		.decode_allowin (decode_allowin),
		.fetch_valid    (fetch_valid),
		.fetch_pc       (fetch_pc),
		.fetch_inst     (fetch_inst),
		.fetch_fault    (fetch_fault),
		.error_count    (error_count),
		.item_count     (item_count)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic drive_random_inputs();
		redirect_valid = ($unsigned($random(seed)) % 12) == 0; // about one pulse in twelve.
		redirect_target = pc_t'(($unsigned($random(seed)) % TGT_WORDS) * 4);
		decode_allowin = ($unsigned($random(seed)) % 3) != 0; // stalls about a third of the time.
		if (item_count == 0) begin
			redirect_valid = 1'b0; // the first item must come from the reset vector.
		end
	endtask

	initial begin
		seed = 32'h89ca_6238;
		tb_errors = 0;
		rst = 1'b1;
		redirect_valid = 1'b0;
		redirect_target = RESET_PC;
		decode_allowin = 1'b0;
		repeat (RST_CYCLES) @(negedge clk);
		rst = 1'b0;
		repeat (RUN_CYCLES) begin
			drive_random_inputs();
			@(negedge clk);
		end
		if (item_count == 0) begin
			$display("no fetched item came out of the DUT during the whole run");
			tb_errors++;
		end
		$display("errors: %0d, items checked: %0d", error_count + tb_errors, item_count);
		if (error_count + tb_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run did not reach its end", WATCHDOG_NS);
		$display("errors: %0d, items checked: %0d", error_count + 1, item_count);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: prog.hex
// one 32-bit instruction word per line in hex, word 0 first.
00500093
00a00113
002081b3
40208233
0030f2b3
0041e333
0052c3b3
00209413
0020d493
4020d513
00c00593
00b50633
fff60693
00d02023
00002703
00e68463
00108093
fe209ee3
00000797
00078813
123458b7
00c000ef
00008067
0100006f
01f00913
41298a33
00a9aa23
014a2b03
016b0bb3
0ffbfc13
000c0c93
00100073

// File: sim.f
core_pkg.sv
bus_pkg.sv
pc_gen.sv
fetch_ctrl.sv
inst_latch.sv
isram.sv
fetch_top.sv
fetch_checker.sv
fetch_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       ?= fetch_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
